// ==== Makefile ====
TOP = tb_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== bench/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;

    import gb_shell_pkg::*;

    localparam int clk_period   = 4;
    localparam int test_budget  = 3 + 100 + 40 + 40 + 120 + 30 + 50;
    localparam int watch_margin = 200;

    logic          clk_sys = 1'b0;
    logic          rst_n;
    bridge_wr_t    bridge;
    slot_req_t     slot_req;
    load_wr_t      load_wr;
    logic [31:0]   key;
    core_video_t   core_video;
    audio_t        core_audio;
    scaler_video_t video;
    audio_t        audio;
    settings_t     settings;
    palette_t      palette;
    logic          fast_forward;
    logic          core_reset;
    logic [31:0]   lfsr_state;

    always #(clk_period / 2) clk_sys = ~clk_sys;

    gb_shell_top #(
        .reset_cycles  (64),
        .ff_tap_cycles (32)
    ) dut_i (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .bridge       (bridge),
        .slot_req     (slot_req),
        .load_wr      (load_wr),
        .key          (key),
        .core_video   (core_video),
        .core_audio   (core_audio),
        .video        (video),
        .audio        (audio),
        .settings     (settings),
        .palette      (palette),
        .fast_forward (fast_forward),
        .core_reset   (core_reset)
    );

    ////////////////////
    // failure and compare

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_settings(input string name, input settings_t exp, input settings_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            fail_run("settings register mismatch");
        end
    endtask

    task automatic check_palette(input string name, input palette_t exp, input palette_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            fail_run("palette mismatch");
        end
    endtask

    task automatic check_video(input string name, input scaler_video_t exp,
                               input scaler_video_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            fail_run("scaler video mismatch");
        end
    endtask

    task automatic check_audio(input string name, input audio_t exp, input audio_t act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            fail_run("audio mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t ns: %s expected %b actual %b", $time, name, exp, act);
            fail_run("control bit mismatch");
        end
    endtask

    ////////////////////
    // stimulus helpers

    // fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // weighted channel sum with each term truncated
    function automatic logic [7:0] gray_level(input logic [23:0] rgb);
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        r = rgb[23:16];
        g = rgb[15:8];
        b = rgb[7:0];
        return (r / 8'd4) + (r / 8'd32) + (g / 8'd2) + (g / 8'd16)
             + (b / 8'd16) + (b / 8'd32);
    endfunction

    task automatic tick();
        @(negedge clk_sys);
    endtask

    task automatic write_bridge(input logic [31:0] addr, input logic [31:0] data);
        bridge = '{wr: 1'b1, addr: addr, data: data};
        tick();
        bridge.wr = 1'b0;
    endtask

    task automatic send_slot(input logic req, input logic [15:0] id, input logic done);
        slot_req = '{req_wr: req, slot_id: id, all_complete: done};
        tick();
        slot_req = '0;
    endtask

    task automatic press_ff(input logic level);
        key = 32'(level) << key_ff_bit;
    endtask

    ////////////////////
    // tests

    task automatic test_settings();
        settings_t exp;
        int i;
        exp = '0;
        check_settings("settings", exp, settings);
        write_bridge(addr_rumble, 32'h1);
        exp.rumble_en = 1'b1;
        check_settings("settings", exp, settings);
        write_bridge(addr_orig_colors, 32'h1);
        exp.orig_colors = 1'b1;
        check_settings("settings", exp, settings);
        write_bridge(addr_ff_en, 32'h1);
        exp.ff_en = 1'b1;
        check_settings("settings", exp, settings);
        write_bridge(addr_ff_snd, 32'h1);
        exp.ff_snd_en = 1'b1;
        check_settings("settings", exp, settings);
        // only the low two data bits reach the tint
        write_bridge(addr_tint, 32'h6);
        exp.tint = 2'b10;
        check_settings("settings", exp, settings);
        write_bridge(addr_bw, 32'h1);
        exp.bw_en = 1'b1;
        check_settings("settings", exp, settings);
        write_bridge(32'h300, 32'hffff_ffff);
        check_settings("settings", exp, settings);
        write_bridge(addr_rumble, 32'h0);
        write_bridge(addr_orig_colors, 32'h0);
        write_bridge(addr_ff_en, 32'h0);
        write_bridge(addr_ff_snd, 32'h0);
        write_bridge(addr_tint, 32'h0);
        write_bridge(addr_bw, 32'h0);
        check_settings("settings", '0, settings);
        // external reset length
        write_bridge(addr_reset, 32'h0);
        for (i = 0; i < 64; i++) begin
            check_bit("core_reset", 1'b1, core_reset);
            tick();
        end
        check_bit("core_reset", 1'b0, core_reset);
    endtask

    task automatic test_palette();
        logic [127:0] exp;
        logic [31:0]  word;
        int i;
        exp = palette_default;
        check_palette("palette", exp, palette);
        send_slot(1'b1, slot_palette, 1'b0);
        for (i = 0; i < 8; i++) begin
            take_bits(16, word);
            load_wr = '{wr: 1'b1, data: word[15:0]};
            tick();
            load_wr.wr = 1'b0;
            exp = {exp[111:0], word[7:0], word[15:8]};
        end
        check_palette("palette", exp, palette);
        send_slot(1'b0, '0, 1'b1);
        // write outside a download is ignored
        load_wr = '{wr: 1'b1, data: 16'hbeef};
        tick();
        load_wr.wr = 1'b0;
        tick();
        check_palette("palette", exp, palette);
    endtask

    task automatic test_core_reset();
        logic [15:0] ids [6];
        logic        holds [6];
        int i;
        ids   = '{slot_cart, slot_border, slot_palette, slot_cgb_boot, slot_dmg_boot,
                  slot_sgb_boot};
        holds = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
        for (i = 0; i < 6; i++) begin
            send_slot(1'b1, ids[i], 1'b0);
            check_bit("core_reset", holds[i], core_reset);
            tick();
            check_bit("core_reset", holds[i], core_reset);
            send_slot(1'b0, '0, 1'b1);
            check_bit("core_reset", 1'b0, core_reset);
        end
    endtask

    task automatic test_fast_forward();
        int i;
        write_bridge(addr_ff_en, 32'h1);
        // long hold is momentary
        press_ff(1'b1);
        for (i = 0; i < 41; i++) begin
            tick();
            check_bit("fast_forward", 1'b1, fast_forward);
        end
        press_ff(1'b0);
        for (i = 0; i < 6; i++) begin
            tick();
            check_bit("fast_forward", 1'b0, fast_forward);
        end
        // first tap latches
        press_ff(1'b1);
        for (i = 0; i < 5; i++) begin
            tick();
            check_bit("fast_forward", 1'b1, fast_forward);
        end
        press_ff(1'b0);
        tick();
        for (i = 0; i < 10; i++) begin
            tick();
            check_bit("fast_forward", 1'b1, fast_forward);
        end
        // second tap releases
        press_ff(1'b1);
        repeat (5) tick();
        press_ff(1'b0);
        for (i = 0; i < 8; i++) begin
            tick();
            check_bit("fast_forward", 1'b0, fast_forward);
        end
        write_bridge(addr_ff_en, 32'h0);
        press_ff(1'b1);
        for (i = 0; i < 6; i++) begin
            tick();
            check_bit("fast_forward", 1'b0, fast_forward);
        end
        press_ff(1'b0);
        tick();
    endtask

    task automatic test_audio();
        logic [31:0] sample;
        write_bridge(addr_ff_en, 32'h1);
        take_bits(32, sample);
        core_audio = sample;
        tick();
        check_audio("audio", sample, audio);
        press_ff(1'b1);
        take_bits(32, sample);
        core_audio = sample;
        tick();
        check_bit("fast_forward", 1'b1, fast_forward);
        check_audio("audio", '0, audio);
        take_bits(32, sample);
        core_audio = sample;
        write_bridge(addr_ff_snd, 32'h1);
        check_audio("audio", sample, audio);
        write_bridge(addr_ff_snd, 32'h0);
        write_bridge(addr_ff_en, 32'h0);
        press_ff(1'b0);
        tick();
        tick();
        check_bit("fast_forward", 1'b0, fast_forward);
        check_audio("audio", sample, audio);
    endtask

    task automatic test_video();
        logic [31:0] r;
        logic [31:0] blanks;
        logic        active;
        int i;
        for (i = 0; i < 8; i++) begin
            take_bits(24, r);
            take_bits(2, blanks);
            core_video = {blanks[1], blanks[0], 1'b0, 1'b0, r[23:0]};
            active = !(blanks[1] || blanks[0]);
            tick();
            check_video("video", {active, 1'b0, 1'b0, active ? r[23:0] : 24'h0}, video);
        end
        // vsync on the rising edge only
        core_video = {1'b0, 1'b0, 1'b0, 1'b1, r[23:0]};
        tick();
        check_video("video", {1'b1, 1'b0, 1'b1, r[23:0]}, video);
        tick();
        check_video("video", {1'b1, 1'b0, 1'b0, r[23:0]}, video);
        core_video.vs = 1'b0;
        // hsync eight cycles after the rise
        core_video.hs = 1'b1;
        for (i = 1; i <= 10; i++) begin
            tick();
            check_video("video", {1'b1, (i == 8), 1'b0, r[23:0]}, video);
            if (i == 3) begin
                core_video.hs = 1'b0;
            end
        end
        write_bridge(addr_bw, 32'h1);
        for (i = 0; i < 6; i++) begin
            take_bits(24, r);
            core_video = {1'b0, 1'b0, 1'b0, 1'b0, r[23:0]};
            tick();
            check_video("video", {1'b1, 1'b0, 1'b0, {3{gray_level(r[23:0])}}}, video);
        end
        write_bridge(addr_bw, 32'h0);
    endtask

    ////////////////////
    // sequence and watchdog

    initial begin
        rst_n      = 1'b0;
        bridge     = '0;
        slot_req   = '0;
        load_wr    = '0;
        key        = '0;
        core_video = '0;
        core_audio = '0;
        lfsr_state = 32'h99ddf41c;
        repeat (3) tick();
        rst_n = 1'b1;
        tick();
        test_settings();
        test_palette();
        test_core_reset();
        test_fast_forward();
        test_audio();
        test_video();
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(clk_period * (test_budget + watch_margin));
        fail_run("watchdog expired before the test sequence finished");
    end

endmodule

// ==== design/ff_control.sv ====
`timescale 1ns/100ps

module ff_control #(
    parameter int unsigned ff_tap_cycles = 3200000
) (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic [31:0]            key,
    input  gb_shell_pkg::settings_t settings,
    input  logic                   download_active,
    input  gb_shell_pkg::audio_t    core_audio,
    output logic                   fast_forward,
    output gb_shell_pkg::audio_t    audio
);

    import gb_shell_pkg::*;

    localparam int cnt_w = $clog2(ff_tap_cycles + 1);
    localparam logic [cnt_w-1:0] tap_max = cnt_w'(ff_tap_cycles);

    logic             ff_btn;
    logic             ff_last;
    logic             ff_latch;
    logic             ff_was_held;
    logic [cnt_w-1:0] ff_count;

    // no speed-up while a file is coming in
    assign ff_btn = settings.ff_en && key[key_ff_bit] && !download_active;

    ////////////////////
    // tap / hold latch

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            ff_last      <= 1'b0;
            ff_latch     <= 1'b0;
            ff_was_held  <= 1'b0;
            ff_count     <= '0;
            fast_forward <= 1'b0;
        end else begin
            ff_last <= ff_btn;

            // press length saturates at the tap limit
            if (ff_btn && !ff_last) begin
                ff_latch <= 1'b0;
                ff_count <= '0;
            end else if (ff_btn && ff_count < tap_max) begin
                ff_count <= ff_count + 1'b1;
            end

            // on release a short tap sets the latch and the next tap leaves it clear
            if (!ff_btn && ff_last) begin
                ff_was_held <= 1'b0;
                if (ff_count < tap_max && !ff_was_held) begin
                    ff_was_held <= 1'b1;
                    ff_latch    <= 1'b1;
                end
            end

            if (!settings.ff_en) begin
                ff_latch    <= 1'b0;
                ff_was_held <= 1'b0;
            end

            fast_forward <= ff_btn || ff_latch;
        end
    end

    // mute unless ff sound is wanted
    assign audio = (fast_forward && !settings.ff_snd_en) ? '0 : core_audio;

    ff_off_when_disabled: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        $past(!settings.ff_en) && $past(!settings.ff_en, 2) |-> !fast_forward
    );

endmodule

// ==== design/gb_shell_pkg.sv ====
package gb_shell_pkg;

    ////////////////////
    // bridge register map

    localparam logic [31:0] addr_reset       = 32'h050;
    localparam logic [31:0] addr_rumble      = 32'h204;
    localparam logic [31:0] addr_orig_colors = 32'h208;
    localparam logic [31:0] addr_ff_en       = 32'h20C;
    localparam logic [31:0] addr_ff_snd      = 32'h210;
    localparam logic [31:0] addr_tint        = 32'h214;
    localparam logic [31:0] addr_bw          = 32'h218;

    // data slot ids
    localparam logic [15:0] slot_cart     = 16'd1;
    localparam logic [15:0] slot_border   = 16'd2;
    localparam logic [15:0] slot_palette  = 16'd3;
    localparam logic [15:0] slot_cgb_boot = 16'd4;
    localparam logic [15:0] slot_dmg_boot = 16'd5;
    localparam logic [15:0] slot_sgb_boot = 16'd6;

    // r1 trigger in the controller key word
    localparam int key_ff_bit = 9;

    localparam logic [127:0] palette_default = 128'h828214517356305A5F1A3B4900000000;

    ////////////////////
    // bus types

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
    } bridge_wr_t;

    typedef struct packed {
        logic       rumble_en;
        logic       orig_colors;
        logic       ff_en;
        logic       ff_snd_en;
        logic [1:0] tint;
        logic       bw_en;
    } settings_t;

    typedef struct packed {
        logic        req_wr;
        logic [15:0] slot_id;
        logic        all_complete;
    } slot_req_t;

    typedef struct packed {
        logic        wr;
        logic [15:0] data;
    } load_wr_t;

    // four colours, lightest first
    typedef struct packed {
        logic [23:0] pal1;
        logic [23:0] pal2;
        logic [23:0] pal3;
        logic [23:0] pal4;
        logic [31:0] unused;
    } palette_t;

    typedef struct packed {
        logic        hblank;
        logic        vblank;
        logic        hs;
        logic        vs;
        logic [23:0] rgb;
    } core_video_t;

    typedef struct packed {
        logic        de;
        logic        hs;
        logic        vs;
        logic [23:0] rgb;
    } scaler_video_t;

    typedef struct packed {
        logic [15:0] left;
        logic [15:0] right;
    } audio_t;

endpackage

// ==== design/gb_shell_top.sv ====
`timescale 1ns/100ps

module gb_shell_top #(
    parameter int unsigned reset_cycles  = 32'h100000,
    parameter int unsigned ff_tap_cycles = 3200000
) (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  gb_shell_pkg::bridge_wr_t    bridge,
    input  gb_shell_pkg::slot_req_t     slot_req,
    input  gb_shell_pkg::load_wr_t      load_wr,
    input  logic [31:0]                key,
    input  gb_shell_pkg::core_video_t   core_video,
    input  gb_shell_pkg::audio_t        core_audio,
    output gb_shell_pkg::scaler_video_t video,
    output gb_shell_pkg::audio_t        audio,
    output gb_shell_pkg::settings_t     settings,
    output gb_shell_pkg::palette_t      palette,
    output logic                       fast_forward,
    output logic                       core_reset
);

    logic ext_reset;
    logic download_active;

    settings_regs #(
        .reset_cycles (reset_cycles)
    ) settings_regs_i (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .bridge    (bridge),
        .settings  (settings),
        .ext_reset (ext_reset)
    );

    slot_loader slot_loader_i (
        .clk_sys         (clk_sys),
        .rst_n           (rst_n),
        .slot_req        (slot_req),
        .load_wr         (load_wr),
        .ext_reset       (ext_reset),
        .download_active (download_active),
        .palette         (palette),
        .core_reset      (core_reset)
    );

    ff_control #(
        .ff_tap_cycles (ff_tap_cycles)
    ) ff_control_i (
        .clk_sys         (clk_sys),
        .rst_n           (rst_n),
        .key             (key),
        .settings        (settings),
        .download_active (download_active),
        .core_audio      (core_audio),
        .fast_forward    (fast_forward),
        .audio           (audio)
    );

    video_out video_out_i (
        .clk_sys    (clk_sys),
        .rst_n      (rst_n),
        .core_video (core_video),
        .bw_en      (settings.bw_en),
        .video      (video)
    );

endmodule

// ==== design/settings_regs.sv ====
`timescale 1ns/100ps

module settings_regs #(
    parameter int unsigned reset_cycles = 32'h100000
) (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  gb_shell_pkg::bridge_wr_t bridge,
    output gb_shell_pkg::settings_t  settings,
    output logic                    ext_reset
);

    import gb_shell_pkg::*;

    settings_t   settings_q;
    logic [31:0] reset_count;

    ////////////////////
    // option registers

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            settings_q <= '0;
        end else if (bridge.wr) begin
            case (bridge.addr)
                addr_rumble:      settings_q.rumble_en   <= bridge.data[0];
                addr_orig_colors: settings_q.orig_colors <= bridge.data[0];
                addr_ff_en:       settings_q.ff_en       <= bridge.data[0];
                addr_ff_snd:      settings_q.ff_snd_en   <= bridge.data[0];
                // tint carries two mode bits
                addr_tint:        settings_q.tint        <= bridge.data[1:0];
                addr_bw:          settings_q.bw_en       <= bridge.data[0];
                default: begin
                end
            endcase
        end
    end

    ////////////////////
    // external reset timer

    // a new reset write restarts the full count
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            reset_count <= '0;
        end else if (bridge.wr && bridge.addr == addr_reset) begin
            reset_count <= reset_cycles;
        end else if (reset_count != '0) begin
            reset_count <= reset_count - 1'b1;
        end
    end

    assign ext_reset = (reset_count != '0);
    assign settings  = settings_q;

    // reset pulse only ever follows a write to the reset address
    ext_reset_source: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        $rose(ext_reset) |-> $past(bridge.wr && bridge.addr == addr_reset)
    );

endmodule

// ==== design/slot_loader.sv ====
`timescale 1ns/100ps

module slot_loader (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  gb_shell_pkg::slot_req_t slot_req,
    input  gb_shell_pkg::load_wr_t  load_wr,
    input  logic                   ext_reset,
    output logic                   download_active,
    output gb_shell_pkg::palette_t  palette,
    output logic                   core_reset
);

    import gb_shell_pkg::*;

    logic [15:0] slot_id;
    palette_t    palette_q;
    logic        palette_dl;
    logic        cart_dl;
    logic        boot_dl;

    ////////////////////
    // download tracking

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            download_active <= 1'b0;
            slot_id         <= '0;
        end else if (slot_req.req_wr) begin
            download_active <= 1'b1;
            slot_id         <= slot_req.slot_id;
        end else if (slot_req.all_complete) begin
            download_active <= 1'b0;
        end
    end

    // kind of download from the captured id
    assign palette_dl = download_active && (slot_id == slot_palette);
    assign cart_dl    = download_active && (slot_id == slot_cart);
    assign boot_dl    = download_active && (slot_id == slot_cgb_boot ||
                                            slot_id == slot_dmg_boot ||
                                            slot_id == slot_sgb_boot);

    ////////////////////
    // palette shift register

    // words arrive big endian, so the bytes swap on the way in
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            palette_q <= palette_default;
        end else if (palette_dl && load_wr.wr) begin
            palette_q <= {palette_q[111:0], load_wr.data[7:0], load_wr.data[15:8]};
        end
    end

    assign palette = palette_q;

    // core held in reset while code is being replaced
    assign core_reset = ext_reset || cart_dl || boot_dl;

    palette_only_in_download: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (palette_q != $past(palette_q)) && $past(rst_n) |-> $past(download_active)
    );

endmodule

// ==== design/video_out.sv ====
`timescale 1ns/100ps

module video_out (
    input  logic                       clk_sys,
    input  logic                       rst_n,
    input  gb_shell_pkg::core_video_t   core_video,
    input  logic                       bw_en,
    output gb_shell_pkg::scaler_video_t video
);

    logic        de_q;
    logic        hs_q;
    logic        vs_q;
    logic [23:0] rgb_q;
    logic        hs_prev;
    logic        vs_prev;
    logic [2:0]  hs_delay;
    logic        active;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic [7:0]  lum;

    assign active = !(core_video.hblank || core_video.vblank);

    ////////////////////
    // sync and enable

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            de_q     <= 1'b0;
            hs_q     <= 1'b0;
            vs_q     <= 1'b0;
            rgb_q    <= '0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
            hs_delay <= '0;
        end else begin
            de_q <= active;
            // black outside the visible area
            rgb_q <= active ? core_video.rgb : 24'h0;

            // single cycle vsync at the core's rising edge
            vs_q <= core_video.vs && !vs_prev;

            // hsync pushed back so it never lands on the vsync pulse
            hs_q <= (hs_delay == 3'd1);
            if (core_video.hs && !hs_prev) begin
                hs_delay <= 3'd7;
            end else if (hs_delay != '0) begin
                hs_delay <= hs_delay - 1'b1;
            end

            hs_prev <= core_video.hs;
            vs_prev <= core_video.vs;
        end
    end

    ////////////////////
    // grayscale

    assign red   = rgb_q[23:16];
    assign green = rgb_q[15:8];
    assign blue  = rgb_q[7:0];

    // approx 0.28 r + 0.56 g + 0.09 b
    assign lum = (red >> 2) + (red >> 5) + (green >> 1) + (green >> 4)
               + (blue >> 4) + (blue >> 5);

    assign video = '{
        de:  de_q,
        hs:  hs_q,
        vs:  vs_q,
        rgb: bw_en ? {lum, lum, lum} : rgb_q
    };

    hs_single_cycle: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        hs_q |=> !hs_q
    );

endmodule

// ==== tb.f ====
design/gb_shell_pkg.sv
design/settings_regs.sv
design/slot_loader.sv
design/ff_control.sv
design/video_out.sv
design/gb_shell_top.sv
bench/tb_top.sv
